// ==== list.f ====
+incdir+design
design/exec_pkg.sv
design/result_bus_if.sv
design/regfile.sv
design/bypass_net.sv
design/exec_alu.sv
design/exec_pipe.sv
design/dual_exec_top.sv
verif/tb_dual_exec.sv

// ==== verif/tb_dual_exec.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module tb_dual_exec;

    localparam int CLK_PERIOD = 4;
    localparam int NTESTS     = 6;
    // each directed test fits in 40 cycles and the random test is 300 pairs plus drain
    localparam int TEST_CYCLES = 4 + (NTESTS - 1) * 40 + 300 + 10;
    localparam exec_pkg::issue_t NOP = '0;

    typedef struct packed {
        int                                  due;
        int                                  test;
        exec_pkg::result_t [`EXEC_LANES-1:0] res;
    } exp_rec_t;

    logic                                clk;
    logic                                arst_n;
    logic              [`EXEC_LANES-1:0] in_valid;
    exec_pkg::alu_op_e [`EXEC_LANES-1:0] in_op;
    exec_pkg::raddr_t  [`EXEC_LANES-1:0] in_ra1;
    exec_pkg::raddr_t  [`EXEC_LANES-1:0] in_ra2;
    logic              [`EXEC_LANES-1:0] in_use_imm;
    exec_pkg::word_t   [`EXEC_LANES-1:0] in_imm;
    exec_pkg::raddr_t  [`EXEC_LANES-1:0] in_rdst;
    logic              [`EXEC_LANES-1:0] wb_valid;
    exec_pkg::raddr_t  [`EXEC_LANES-1:0] wb_rdst;
    exec_pkg::word_t   [`EXEC_LANES-1:0] wb_data;

    exp_rec_t        exp_q [$];
    exec_pkg::word_t model_regs [`EXEC_NREG];
    logic [31:0]     lfsr_state = 32'd79;
    int              cyc = 0;
    int              n_checks = 0;
    int              n_errs = 0;
    int              test_checks [NTESTS] = '{default: 0};
    int              test_errs [NTESTS] = '{default: 0};
    string           test_names [NTESTS] = '{"reset", "alu_ops", "forwarding",
                                             "conflicts", "reg_zero", "random"};
    // sign, shift and bit pattern corners for the opcode sweep
    exec_pkg::word_t seeds [8] = '{32'h0000_0007, 32'hffff_fff0, 32'h1234_5678,
                                   32'h8000_0001, 32'h0000_001f, 32'h0f0f_0f0f,
                                   32'h7fff_ffff, 32'h0000_0003};

    dual_exec_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_ra1     (in_ra1),
        .in_ra2     (in_ra2),
        .in_use_imm (in_use_imm),
        .in_imm     (in_imm),
        .in_rdst    (in_rdst),
        .wb_valid   (wb_valid),
        .wb_rdst    (wb_rdst),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // galois form of x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic exec_pkg::issue_t reg_op(exec_pkg::alu_op_e code, int dst, int s1, int s2);
        return '{valid: 1'b1, op: code, ra1: exec_pkg::raddr_t'(s1),
                 ra2: exec_pkg::raddr_t'(s2), use_imm: 1'b0, imm: '0,
                 rdst: exec_pkg::raddr_t'(dst)};
    endfunction

    function automatic exec_pkg::issue_t imm_op(exec_pkg::alu_op_e code, int dst, int s1,
                                                exec_pkg::word_t value);
        return '{valid: 1'b1, op: code, ra1: exec_pkg::raddr_t'(s1), ra2: '0,
                 use_imm: 1'b1, imm: value, rdst: exec_pkg::raddr_t'(dst)};
    endfunction

    // registers limited to r0..r7 so hazards are dense
    function automatic exec_pkg::issue_t rand_instr();
        exec_pkg::issue_t ins;
        ins.valid   = (rand_bits(2) != 0);
        ins.op      = exec_pkg::alu_op_e'(rand_bits(3));
        ins.ra1     = exec_pkg::raddr_t'(rand_bits(3));
        ins.ra2     = exec_pkg::raddr_t'(rand_bits(3));
        ins.use_imm = 1'(rand_bits(1));
        ins.imm     = rand_bits(32);
        ins.rdst    = exec_pkg::raddr_t'(rand_bits(3));
        return ins;
    endfunction

    // expected result from the model state before the pair
    function automatic exec_pkg::word_t ref_result(exec_pkg::issue_t ins);
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        exec_pkg::word_t y;
        a = model_regs[ins.ra1];
        b = ins.use_imm ? ins.imm : model_regs[ins.ra2];
        case (ins.op)
            exec_pkg::ADD: y = a + b;
            exec_pkg::SUB: y = a - b;
            exec_pkg::AND: y = a & b;
            exec_pkg::OR:  y = a | b;
            exec_pkg::XOR: y = a ^ b;
            exec_pkg::SLL: y = a << b[4:0];
            exec_pkg::SRL: y = a >> b[4:0];
            // signs differ means a is less exactly when it is negative
            exec_pkg::SLT: y = (a[31] != b[31]) ? 32'(a[31]) : 32'(a < b);
            default:       y = 'x;
        endcase
        return y;
    endfunction

    task automatic issue_pair(input int test, input exec_pkg::issue_t i0,
                              input exec_pkg::issue_t i1);
        exec_pkg::issue_t ins [`EXEC_LANES];
        exp_rec_t         rec;
        ins[0] = i0;
        ins[1] = i1;
        @(posedge clk);
        rec.due  = cyc + 3;
        rec.test = test;
        for (int l = 0; l < `EXEC_LANES; l++) begin
            in_valid[l]   <= ins[l].valid;
            in_op[l]      <= ins[l].op;
            in_ra1[l]     <= ins[l].ra1;
            in_ra2[l]     <= ins[l].ra2;
            in_use_imm[l] <= ins[l].use_imm;
            in_imm[l]     <= ins[l].imm;
            in_rdst[l]    <= ins[l].rdst;
            rec.res[l] = '{valid: ins[l].valid, rdst: ins[l].rdst,
                           data: ins[l].valid ? ref_result(ins[l]) : '0};
        end
        // lane 1 updates the model last and r0 is never written
        for (int l = 0; l < `EXEC_LANES; l++) begin
            if (ins[l].valid && ins[l].rdst != '0) begin
                model_regs[ins[l].rdst] = rec.res[l].data;
            end
        end
        exp_q.push_back(rec);
    endtask

    task automatic finish_test(input int test);
        @(posedge clk);
        in_valid <= '0;
        while (exp_q.size() != 0) @(posedge clk);
        $display("%-10s %s  %0d checks, %0d errors", test_names[test],
                 (test_errs[test] == 0) ? "ok" : "FAILED", test_checks[test],
                 test_errs[test]);
    endtask

    task automatic check_result(input int test, input int lane,
                                input exec_pkg::result_t exp, input exec_pkg::result_t act);
        n_checks++;
        test_checks[test]++;
        if (act !== exp) begin
            n_errs++;
            test_errs[test]++;
            $display("FAIL %s lane %0d: expected v=%0b rd=%0d d=%h, actual v=%0b rd=%0d d=%h",
                     test_names[test], lane, exp.valid, exp.rdst, exp.data,
                     act.valid, act.rdst, act.data);
        end
    endtask

    task automatic check_valid(input int test, input int lane, input logic exp, input logic act);
        n_checks++;
        test_checks[test]++;
        if (act !== exp) begin
            n_errs++;
            test_errs[test]++;
            $display("FAIL %s lane %0d: expected wb_valid=%0b, actual wb_valid=%0b",
                     test_names[test], lane, exp, act);
        end
    endtask

    // wb values seen at an edge are the ones from the cycle before it
    initial begin
        exp_rec_t          rec;
        exec_pkg::result_t act;
        forever begin
            @(posedge clk);
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                rec = exp_q[0];
                for (int l = 0; l < `EXEC_LANES; l++) begin
                    act = '{valid: wb_valid[l], rdst: wb_rdst[l], data: wb_data[l]};
                    if (rec.res[l].valid) begin
                        check_result(rec.test, l, rec.res[l], act);
                    end else begin
                        check_valid(rec.test, l, 1'b0, wb_valid[l]);
                    end
                end
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 100);
        $display("watchdog: tests did not finish within %0d cycles", TEST_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        exec_pkg::issue_t lane0_ins;
        exec_pkg::issue_t lane1_ins;
        arst_n     = 1'b0;
        // a valid pair waits at the port throughout reset
        in_valid   = '1;
        in_op      = '{default: exec_pkg::ADD};
        in_ra1     = '{default: exec_pkg::raddr_t'(1)};
        in_ra2     = '0;
        in_use_imm = '1;
        in_imm     = '1;
        in_rdst    = '{default: exec_pkg::raddr_t'(1)};
        for (int r = 0; r < `EXEC_NREG; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        arst_n   <= 1'b1;
        in_valid <= '0;

        // the pair held during reset must not reach write-back
        repeat (3) begin
            @(posedge clk);
            for (int l = 0; l < `EXEC_LANES; l++) begin
                check_valid(0, l, 1'b0, wb_valid[l]);
            end
        end

        // wb stays low until the first pair has passed E and M
        repeat (3) issue_pair(0, NOP, NOP);
        issue_pair(0, imm_op(exec_pkg::ADD, 1, 0, 32'h5), NOP);
        issue_pair(0, NOP, NOP);
        finish_test(0);

        for (int k = 0; k < 8; k += 2) begin
            issue_pair(1, imm_op(exec_pkg::ADD, k + 1, 0, seeds[k]),
                       imm_op(exec_pkg::ADD, k + 2, 0, seeds[k + 1]));
        end
        issue_pair(1, NOP, NOP);
        issue_pair(1, NOP, NOP);
        for (int k = 0; k < 8; k++) begin
            issue_pair(1, reg_op(exec_pkg::alu_op_e'(k), 16 + k, 1 + k, 8 - k),
                       imm_op(exec_pkg::alu_op_e'(k), 24 + k, 1 + (k + 3) % 8,
                              32'hffff_fff9 - 7 * k));
        end
        finish_test(1);

        issue_pair(2, imm_op(exec_pkg::ADD, 9, 1, 32'd100),
                   imm_op(exec_pkg::SUB, 10, 2, 32'd1));
        // E forwarding from the pair just before
        issue_pair(2, reg_op(exec_pkg::ADD, 11, 9, 10), reg_op(exec_pkg::XOR, 12, 9, 1));
        // E from the last pair and M from the one before it
        issue_pair(2, reg_op(exec_pkg::SUB, 13, 11, 9), reg_op(exec_pkg::OR, 14, 12, 10));
        issue_pair(2, reg_op(exec_pkg::SLL, 9, 13, 8), reg_op(exec_pkg::AND, 10, 14, 11));
        issue_pair(2, reg_op(exec_pkg::ADD, 15, 9, 10), reg_op(exec_pkg::SLT, 16, 10, 9));
        finish_test(2);

        // both lanes write one register and lane 1 must win everywhere
        issue_pair(3, imm_op(exec_pkg::ADD, 17, 0, 32'h111),
                   imm_op(exec_pkg::ADD, 17, 0, 32'h222));
        issue_pair(3, reg_op(exec_pkg::ADD, 18, 17, 0), NOP);
        issue_pair(3, reg_op(exec_pkg::OR, 19, 17, 0), NOP);
        issue_pair(3, reg_op(exec_pkg::XOR, 20, 17, 1), NOP);
        // lane 1 reads lane 0's destination and must see the old value
        issue_pair(3, imm_op(exec_pkg::ADD, 21, 0, 32'h55), reg_op(exec_pkg::ADD, 22, 21, 17));
        issue_pair(3, reg_op(exec_pkg::ADD, 23, 21, 22), NOP);
        finish_test(3);

        issue_pair(4, imm_op(exec_pkg::ADD, 0, 1, 32'd9), reg_op(exec_pkg::ADD, 0, 2, 3));
        issue_pair(4, reg_op(exec_pkg::OR, 24, 0, 0), imm_op(exec_pkg::ADD, 25, 0, 32'd0));
        issue_pair(4, reg_op(exec_pkg::ADD, 26, 0, 1), reg_op(exec_pkg::SUB, 27, 1, 0));
        issue_pair(4, reg_op(exec_pkg::XOR, 28, 0, 0), NOP);
        finish_test(4);

        for (int n = 0; n < 300; n++) begin
            lane0_ins = rand_instr();
            lane1_ins = rand_instr();
            issue_pair(5, lane0_ins, lane1_ins);
        end
        finish_test(5);

        $display("checks: %0d, errors: %0d", n_checks, n_errs);
        if (n_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== design/dual_exec_top.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module dual_exec_top (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic              [`EXEC_LANES-1:0] in_valid,
    input  exec_pkg::alu_op_e [`EXEC_LANES-1:0] in_op,
    input  exec_pkg::raddr_t  [`EXEC_LANES-1:0] in_ra1,
    input  exec_pkg::raddr_t  [`EXEC_LANES-1:0] in_ra2,
    input  logic              [`EXEC_LANES-1:0] in_use_imm,
    input  exec_pkg::word_t   [`EXEC_LANES-1:0] in_imm,
    input  exec_pkg::raddr_t  [`EXEC_LANES-1:0] in_rdst,
    output logic              [`EXEC_LANES-1:0] wb_valid,
    output exec_pkg::raddr_t  [`EXEC_LANES-1:0] wb_rdst,
    output exec_pkg::word_t   [`EXEC_LANES-1:0] wb_data
);

    exec_pkg::issue_t  [`EXEC_LANES-1:0]   issue;
    exec_pkg::raddr_t  [2*`EXEC_LANES-1:0] rd_addr;
    exec_pkg::word_t   [2*`EXEC_LANES-1:0] rd_data;
    exec_pkg::word_t   [`EXEC_LANES-1:0]   byp_opa;
    exec_pkg::word_t   [`EXEC_LANES-1:0]   byp_opb;
    exec_pkg::alu_op_e [`EXEC_LANES-1:0]   alu_op;
    exec_pkg::word_t   [`EXEC_LANES-1:0]   alu_opa;
    exec_pkg::word_t   [`EXEC_LANES-1:0]   alu_opb;
    exec_pkg::word_t   [`EXEC_LANES-1:0]   alu_res;

    result_bus_if bus_e ();
    result_bus_if bus_m ();

    for (genvar l = 0; l < `EXEC_LANES; l++) begin : g_lane
        assign issue[l] = '{
            valid:   in_valid[l],
            op:      in_op[l],
            ra1:     in_ra1[l],
            ra2:     in_ra2[l],
            use_imm: in_use_imm[l],
            imm:     in_imm[l],
            rdst:    in_rdst[l]
        };

        // two read ports per lane
        assign rd_addr[2*l]   = in_ra1[l];
        assign rd_addr[2*l+1] = in_ra2[l];

        // write-back view is the M stage
        assign wb_valid[l] = bus_m.res[l].valid;
        assign wb_rdst[l]  = bus_m.res[l].rdst;
        assign wb_data[l]  = bus_m.res[l].data;

        exec_alu u_alu (
            .op     (alu_op[l]),
            .opa    (alu_opa[l]),
            .opb    (alu_opb[l]),
            .result (alu_res[l])
        );
    end

    regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wb      (bus_m)
    );

    bypass_net u_bypass (
        .issue   (issue),
        .rf_data (rd_data),
        .e_bus   (bus_e),
        .m_bus   (bus_m),
        .opa     (byp_opa),
        .opb     (byp_opb)
    );

    exec_pipe u_pipe (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .byp_opa (byp_opa),
        .byp_opb (byp_opb),
        .alu_op  (alu_op),
        .alu_opa (alu_opa),
        .alu_opb (alu_opb),
        .alu_res (alu_res),
        .e_bus   (bus_e),
        .m_bus   (bus_m)
    );

endmodule

// ==== design/exec_pipe.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_pipe (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  exec_pkg::issue_t  [`EXEC_LANES-1:0]   issue,
    input  exec_pkg::word_t   [`EXEC_LANES-1:0]   byp_opa,
    input  exec_pkg::word_t   [`EXEC_LANES-1:0]   byp_opb,
    output exec_pkg::alu_op_e [`EXEC_LANES-1:0]   alu_op,
    output exec_pkg::word_t   [`EXEC_LANES-1:0]   alu_opa,
    output exec_pkg::word_t   [`EXEC_LANES-1:0]   alu_opb,
    input  exec_pkg::word_t   [`EXEC_LANES-1:0]   alu_res,
    result_bus_if.producer                        e_bus,
    result_bus_if.producer                        m_bus
);

    logic              [`EXEC_LANES-1:0] e_valid;
    exec_pkg::alu_op_e [`EXEC_LANES-1:0] e_op;
    exec_pkg::word_t   [`EXEC_LANES-1:0] e_opa;
    exec_pkg::word_t   [`EXEC_LANES-1:0] e_opb;
    exec_pkg::raddr_t  [`EXEC_LANES-1:0] e_rdst;
    exec_pkg::result_t [`EXEC_LANES-1:0] e_res;

    logic              [`EXEC_LANES-1:0] m_valid;
    exec_pkg::raddr_t  [`EXEC_LANES-1:0] m_rdst;
    exec_pkg::word_t   [`EXEC_LANES-1:0] m_data;

    // valid bits of both stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_valid <= '0;
            m_valid <= '0;
        end else begin
            for (int l = 0; l < `EXEC_LANES; l++) begin
                e_valid[l] <= issue[l].valid;
            end
            m_valid <= e_valid;
        end
    end

    // payload, operands already resolved by the bypass network
    always_ff @(posedge clk) begin
        for (int l = 0; l < `EXEC_LANES; l++) begin
            e_op[l]   <= issue[l].op;
            e_rdst[l] <= issue[l].rdst;
            e_opa[l]  <= byp_opa[l];
            e_opb[l]  <= byp_opb[l];
            m_rdst[l] <= e_rdst[l];
            m_data[l] <= e_res[l].data;
        end
    end

    assign alu_op  = e_op;
    assign alu_opa = e_opa;
    assign alu_opb = e_opb;

    for (genvar l = 0; l < `EXEC_LANES; l++) begin : g_bus
        // E result is the ALU output of this cycle
        assign e_res[l] = '{valid: e_valid[l], rdst: e_rdst[l], data: alu_res[l]};
        assign m_bus.res[l] = '{valid: m_valid[l], rdst: m_rdst[l], data: m_data[l]};
    end

    assign e_bus.res = e_res;

    // nothing can reach M until a pair has spent a cycle in E
    a_clean_start: assert property (
        @(posedge clk) $rose(arst_n) |-> (e_valid == '0 && m_valid == '0) ##1 (m_valid == '0)
    ) else $error("stage valid set right after reset");

endmodule

// ==== design/exec_alu.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_alu (
    input  exec_pkg::alu_op_e op,
    input  exec_pkg::word_t   opa,
    input  exec_pkg::word_t   opb,
    output exec_pkg::word_t   result
);

    // only the low bits of opb count as shift amount
    logic [$clog2(`EXEC_XLEN)-1:0] shamt;

    // signed view for SLT
    logic signed [`EXEC_XLEN-1:0] sa;
    logic signed [`EXEC_XLEN-1:0] sb;

    assign shamt = opb[$clog2(`EXEC_XLEN)-1:0];
    assign sa    = opa;
    assign sb    = opb;

    always_comb begin
        unique case (op)
            exec_pkg::ADD: result = opa + opb;
            exec_pkg::SUB: result = opa - opb;
            exec_pkg::AND: result = opa & opb;
            exec_pkg::OR:  result = opa | opb;
            exec_pkg::XOR: result = opa ^ opb;
            exec_pkg::SLL: result = opa << shamt;
            // logical shift, zero fill
            exec_pkg::SRL: result = opa >> shamt;
            exec_pkg::SLT: result = {{(`EXEC_XLEN-1){1'b0}}, (sa < sb)};
            default:       result = '0;
        endcase
    end

endmodule

// ==== design/bypass_net.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module bypass_net (
    input  exec_pkg::issue_t [`EXEC_LANES-1:0]   issue,
    input  exec_pkg::word_t  [2*`EXEC_LANES-1:0] rf_data,
    result_bus_if.consumer                       e_bus,
    result_bus_if.consumer                       m_bus,
    output exec_pkg::word_t  [`EXEC_LANES-1:0]   opa,
    output exec_pkg::word_t  [`EXEC_LANES-1:0]   opb
);

    // newest in-flight value of one source register
    function automatic exec_pkg::word_t resolve(
        input exec_pkg::raddr_t                    ra,
        input exec_pkg::word_t                     rf_val,
        input exec_pkg::result_t [`EXEC_LANES-1:0] e_res,
        input exec_pkg::result_t [`EXEC_LANES-1:0] m_res
    );
        exec_pkg::word_t val;
        val = rf_val;
        // oldest first so the youngest hit is the one that stays:
        // M lane 0, M lane 1, E lane 0, E lane 1
        for (int l = 0; l < `EXEC_LANES; l++) begin
            if (m_res[l].valid && m_res[l].rdst == ra && ra != '0) begin
                val = m_res[l].data;
            end
        end
        for (int l = 0; l < `EXEC_LANES; l++) begin
            if (e_res[l].valid && e_res[l].rdst == ra && ra != '0) begin
                val = e_res[l].data;
            end
        end
        return val;
    endfunction

    for (genvar l = 0; l < `EXEC_LANES; l++) begin : g_lane
        exec_pkg::word_t src1;
        exec_pkg::word_t src2;

        // rf ports are ordered ra1, ra2 per lane
        assign src1 = resolve(issue[l].ra1, rf_data[2*l], e_bus.res, m_bus.res);
        assign src2 = resolve(issue[l].ra2, rf_data[2*l+1], e_bus.res, m_bus.res);

        assign opa[l] = src1;
        assign opb[l] = issue[l].use_imm ? issue[l].imm : src2;

        // register 0 must come out as zero whatever is in flight
        always_comb begin
            if (issue[l].valid) begin
                a_ra1_zero: assert final (issue[l].ra1 != '0 || opa[l] == '0)
                    else $error("lane %0d ra1 = r0 gave nonzero operand", l);
                a_ra2_zero: assert final (issue[l].use_imm || issue[l].ra2 != '0
                                          || opb[l] == '0)
                    else $error("lane %0d ra2 = r0 gave nonzero operand", l);
            end
        end
    end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module regfile (
    input  logic                                clk,
    input  logic                                arst_n,
    input  exec_pkg::raddr_t [2*`EXEC_LANES-1:0] rd_addr,
    output exec_pkg::word_t  [2*`EXEC_LANES-1:0] rd_data,
    result_bus_if.consumer                      wb
);

    exec_pkg::word_t regs [`EXEC_NREG];

    // write back from M at the end of the stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < `EXEC_NREG; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // lane 1 written last so it wins a clash
            for (int l = 0; l < `EXEC_LANES; l++) begin
                if (wb.res[l].valid && wb.res[l].rdst != '0) begin
                    regs[wb.res[l].rdst] <= wb.res[l].data;
                end
            end
        end
    end

    // combinational read ports, two per lane
    for (genvar p = 0; p < 2*`EXEC_LANES; p++) begin : g_rd
        assign rd_data[p] = regs[rd_addr[p]];

        a_reg0_zero: assert property (
            @(posedge clk) disable iff (!arst_n)
            rd_addr[p] == '0 |-> rd_data[p] == '0
        ) else $error("register 0 read back nonzero on port %0d", p);
    end

endmodule

// ==== design/result_bus_if.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

// per-lane results of one pipeline stage
interface result_bus_if;

    // a valid entry is present for exactly one cycle, no handshake
    exec_pkg::result_t [`EXEC_LANES-1:0] res;

    // stage registers drive the bus
    modport producer (
        output res
    );

    // bypass network and register file write port
    modport consumer (
        input res
    );

endinterface

// ==== design/exec_pkg.sv ====
`include "exec_cfg.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;
    typedef logic [`EXEC_RAW-1:0]  raddr_t;

    // integer opcodes, all of them write a register
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // one lane at the issue port
    typedef struct packed {
        logic    valid;
        alu_op_e op;
        raddr_t  ra1;
        raddr_t  ra2;
        // immediate takes the place of the second source
        logic    use_imm;
        word_t   imm;
        raddr_t  rdst;
    } issue_t;

    // one lane's result in E or M
    typedef struct packed {
        logic   valid;
        raddr_t rdst;
        word_t  data;
    } result_t;

endpackage

// ==== design/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath width
`define EXEC_XLEN 32

// architectural registers, register 0 hardwired to zero
`define EXEC_NREG 32

// issue width, lane 1 is the younger instruction
`define EXEC_LANES 2

// register address width
`define EXEC_RAW $clog2(`EXEC_NREG)

`endif
